/* Bender.yml */
package:
  name: xadc_monitor

sources:
  # Design, in compile order
  - source/xadc_drp_package.sv
  - source/xadc_bfm.sv
  - source/drp_read_sequencer.sv
  - source/drp_watchdog_timer.sv
  - source/measurement_store.sv
  - source/xadc_monitor_top.sv

  # Testbench
  - target: test
    files:
      - testbench/xadc_monitor_asserts.sv
      - testbench/xadc_monitor_checker.sv
      - testbench/xadc_monitor_tb.sv

/* source/drp_read_sequencer.sv */
`timescale 1ns/1ps

module drp_read_sequencer (
    input  logic dclk_in,
    input  logic reset_in,
    // Converter status and DRP return path
    input  logic eos,
    input  logic drdy,
    input  logic [xadc_drp_package::XADC_DRP_DATA_WIDTH-1:0] drp_data,
    // Watchdog
    input  logic expired,
    output xadc_drp_package::drp_req_t drp_req,
    output logic timer_start,
    output logic timer_stop,
    // Measurement record to the store
    output xadc_drp_package::measurement_t sample,
    output logic new_sample,
    output logic fault,
    output logic busy
);
    import xadc_drp_package::*;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_WAIT_CURRENT,
        SEQ_WAIT_VOLTAGE
    } seq_state_t;

    seq_state_t state;

    always_ff @(posedge dclk_in) begin
        if (reset_in) begin
            state <= SEQ_IDLE;
            drp_req <= '0;
            timer_start <= 1'b0;
            timer_stop <= 1'b0;
            new_sample <= 1'b0;
            fault <= 1'b0;
            busy <= 1'b0;
        end else begin
            // All strobes are single cycle
            drp_req.den <= 1'b0;
            timer_start <= 1'b0;
            timer_stop <= 1'b0;
            new_sample <= 1'b0;
            fault <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    // Sequence done in the converter, fetch the current first
                    if (eos) begin
                        drp_req.den <= 1'b1;
                        drp_req.daddr <= XADC_DRP_ADDR_CURRENT_CHANNEL;
                        timer_start <= 1'b1;
                        busy <= 1'b1;
                        state <= SEQ_WAIT_CURRENT;
                    end
                end
                SEQ_WAIT_CURRENT: begin
                    if (drdy) begin
                        // Close this read and open the voltage read at once
                        timer_stop <= 1'b1;
                        drp_req.den <= 1'b1;
                        drp_req.daddr <= XADC_DRP_ADDR_VOLTAGE_CHANNEL;
                        timer_start <= 1'b1;
                        state <= SEQ_WAIT_VOLTAGE;
                    end else if (expired) begin
                        fault <= 1'b1;
                        busy <= 1'b0;
                        state <= SEQ_IDLE;
                    end
                end
                SEQ_WAIT_VOLTAGE: begin
                    if (drdy) begin
                        timer_stop <= 1'b1;
                        new_sample <= 1'b1;
                        busy <= 1'b0;
                        state <= SEQ_IDLE;
                    end else if (expired) begin
                        // Half a record is thrown away
                        fault <= 1'b1;
                        busy <= 1'b0;
                        state <= SEQ_IDLE;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // Capture each returned word into its field
    always_ff @(posedge dclk_in) begin
        if (drdy && state == SEQ_WAIT_CURRENT) begin
            sample.current <= drp_data;
        end
        if (drdy && state == SEQ_WAIT_VOLTAGE) begin
            sample.voltage <= drp_data;
        end
    end

endmodule

/* source/drp_watchdog_timer.sv */
`timescale 1ns/1ps

module drp_watchdog_timer (
    input  logic dclk_in,
    input  logic reset_in,
    input  logic timer_start,
    input  logic timer_stop,
    output logic expired
);
    import xadc_drp_package::*;

    // Cycles left for the outstanding read
    logic [DRP_TIMER_WIDTH-1:0] count;
    logic armed;

    always_ff @(posedge dclk_in) begin
        if (reset_in) begin
            count <= '0;
            armed <= 1'b0;
            expired <= 1'b0;
        end else begin
            expired <= 1'b0;
            // A new read wins over the stop of the previous one
            if (timer_start) begin
                count <= DRP_TIMER_WIDTH'(DRP_TIMEOUT_CYCLES);
                armed <= 1'b1;
            end else if (timer_stop) begin
                count <= '0;
                armed <= 1'b0;
            end else if (armed) begin
                // Fire once as the count hits zero
                if (count == DRP_TIMER_WIDTH'(1)) begin
                    expired <= 1'b1;
                    armed <= 1'b0;
                end
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* source/measurement_store.sv */
`timescale 1ns/1ps

module measurement_store (
    input  logic dclk_in,
    input  logic reset_in,
    input  xadc_drp_package::measurement_t sample,
    input  logic new_sample,
    input  logic fault,
    input  logic clear_peak,
    output xadc_drp_package::measurement_t measurement,
    output logic sample_valid,
    output logic [xadc_drp_package::XADC_DRP_DATA_WIDTH-1:0] peak_current,
    output logic [xadc_drp_package::FAULT_COUNT_WIDTH-1:0] fault_count
);
    // Clear seen, waiting for the next sample
    logic clear_pending;

    always_ff @(posedge dclk_in) begin
        if (reset_in) begin
            measurement <= '0;
            sample_valid <= 1'b0;
            peak_current <= '0;
            clear_pending <= 1'b0;
            fault_count <= '0;
        end else begin
            sample_valid <= new_sample;
            if (new_sample) begin
                measurement <= sample;
                // After a clear the new current is taken as is
                if (clear_peak || clear_pending || sample.current > peak_current) begin
                    peak_current <= sample.current;
                end
                clear_pending <= 1'b0;
            end else if (clear_peak) begin
                clear_pending <= 1'b1;
            end
            // Saturate at all ones
            if (fault && fault_count != '1) begin
                fault_count <= fault_count + 1'b1;
            end
        end
    end

endmodule

/* source/xadc_bfm.sv */
`timescale 1ns/1ps

module xadc_bfm (
    input  logic dclk_in,
    input  logic reset_in,
    // DRP port, reads only
    input  xadc_drp_package::drp_req_t drp_req,
    input  logic [xadc_drp_package::XADC_DRP_DATA_WIDTH-1:0] di_in,
    input  logic dwe_in,
    output logic drdy_out,
    output logic [xadc_drp_package::XADC_DRP_DATA_WIDTH-1:0] do_out,
    // Dedicated and auxiliary analog pins, ignored by the model
    input  logic vp_in,
    input  logic vn_in,
    input  logic vauxp4,
    input  logic vauxn4,
    input  logic vauxp12,
    input  logic vauxn12,
    // Conversion status
    output logic [4:0] channel_out,
    output logic eoc_out,
    output logic alarm_out,
    output logic eos_out,
    output logic busy_out
);
    import xadc_drp_package::*;

    typedef enum logic [2:0] {
        INIT,
        IDLE,
        PULSE_EOS,
        AWAIT_READ,
        READ_WAIT,
        PREP_READ,
        SHOW_READ
    } bfm_state_t;

    bfm_state_t state;

    // Fake conversion results
    logic [XADC_DRP_DATA_WIDTH-1:0] current_conv;
    logic [XADC_DRP_DATA_WIDTH-1:0] voltage_conv;
    // Word picked by the last accepted address
    logic [XADC_DRP_DATA_WIDTH-1:0] conv_value;
    // Set when the read in flight targets the voltage channel
    logic read_voltage;

    always_ff @(posedge dclk_in) begin
        if (reset_in) begin
            state <= INIT;
            drdy_out <= 1'b0;
            channel_out <= '0;
            eoc_out <= 1'b0;
            alarm_out <= 1'b0;
            eos_out <= 1'b0;
            busy_out <= 1'b0;
            read_voltage <= 1'b0;
        end else begin
            case (state)
                INIT: begin
                    // Load the ramp start values, first sequence ends now
                    current_conv <= CURRENT_INIT;
                    voltage_conv <= VOLTAGE_INIT;
                    eoc_out <= 1'b1;
                    busy_out <= 1'b1;
                    channel_out <= XADC_CHANNEL_VAUX12;
                    state <= IDLE;
                end
                IDLE: begin
                    // EOS follows the last EOC by one cycle
                    eoc_out <= 1'b0;
                    busy_out <= 1'b0;
                    eos_out <= 1'b1;
                    state <= PULSE_EOS;
                end
                PULSE_EOS: begin
                    eos_out <= 1'b0;
                    state <= AWAIT_READ;
                end
                AWAIT_READ: begin
                    // Unknown addresses are dropped here and never see drdy
                    if (drp_req.den) begin
                        if (drp_req.daddr == XADC_DRP_ADDR_CURRENT_CHANNEL) begin
                            conv_value <= current_conv;
                            read_voltage <= 1'b0;
                            state <= READ_WAIT;
                        end else if (drp_req.daddr == XADC_DRP_ADDR_VOLTAGE_CHANNEL) begin
                            conv_value <= voltage_conv;
                            read_voltage <= 1'b1;
                            state <= READ_WAIT;
                        end
                    end
                end
                // Register file latency
                READ_WAIT: state <= PREP_READ;
                PREP_READ: begin
                    drdy_out <= 1'b1;
                    do_out <= conv_value;
                    state <= SHOW_READ;
                end
                SHOW_READ: begin
                    drdy_out <= 1'b0;
                    if (read_voltage) begin
                        // Sequence read out, step both ramps and convert again
                        current_conv <= current_conv + CURRENT_STEP;
                        voltage_conv <= voltage_conv + VOLTAGE_STEP;
                        eoc_out <= 1'b1;
                        busy_out <= 1'b1;
                        channel_out <= XADC_CHANNEL_VAUX12;
                        state <= IDLE;
                    end else begin
                        state <= AWAIT_READ;
                    end
                end
                default: state <= INIT;
            endcase
        end
    end

endmodule

/* source/xadc_drp_package.sv */
package xadc_drp_package;

    // DRP bus widths
    localparam int XADC_DRP_DATA_WIDTH = 16;
    localparam int XADC_DRP_AXIS_ADDR_WIDTH = 7;

    // Result registers of the two auxiliary inputs
    localparam logic [XADC_DRP_AXIS_ADDR_WIDTH-1:0] XADC_DRP_ADDR_CURRENT_CHANNEL = 7'h14;
    localparam logic [XADC_DRP_AXIS_ADDR_WIDTH-1:0] XADC_DRP_ADDR_VOLTAGE_CHANNEL = 7'h1c;

    // Channel numbers as shown on the status port
    localparam logic [4:0] XADC_CHANNEL_VAUX4 = 5'd20;
    localparam logic [4:0] XADC_CHANNEL_VAUX12 = 5'd28;

    // Longest wait for drdy before a read is abandoned
    localparam int DRP_TIMEOUT_CYCLES = 16;
    localparam int DRP_TIMER_WIDTH = $clog2(DRP_TIMEOUT_CYCLES + 1);

    // Saturating fault counter width
    localparam int FAULT_COUNT_WIDTH = 8;

    // Fake conversion ramps of the simulated converter
    localparam logic [XADC_DRP_DATA_WIDTH-1:0] CURRENT_INIT = 16'd127;
    localparam logic [XADC_DRP_DATA_WIDTH-1:0] CURRENT_STEP = 16'd3;
    localparam logic [XADC_DRP_DATA_WIDTH-1:0] VOLTAGE_INIT = 16'd255;
    localparam logic [XADC_DRP_DATA_WIDTH-1:0] VOLTAGE_STEP = 16'd5;

    // Read request from the sequencer into the converter
    typedef struct packed {
        logic den;
        logic [XADC_DRP_AXIS_ADDR_WIDTH-1:0] daddr;
    } drp_req_t;

    // One published measurement record
    typedef struct packed {
        logic [XADC_DRP_DATA_WIDTH-1:0] current;
        logic [XADC_DRP_DATA_WIDTH-1:0] voltage;
    } measurement_t;

endpackage

/* source/xadc_monitor_top.sv */
`timescale 1ns/1ps

module xadc_monitor_top (
    input  logic dclk_in,
    input  logic reset_in,
    input  logic clear_peak,
    output xadc_drp_package::measurement_t measurement,
    output logic sample_valid,
    output logic [xadc_drp_package::XADC_DRP_DATA_WIDTH-1:0] peak_current,
    output logic [xadc_drp_package::FAULT_COUNT_WIDTH-1:0] fault_count,
    output logic busy
);
    import xadc_drp_package::*;

    // DRP link
    drp_req_t drp_req;
    logic drdy;
    logic [XADC_DRP_DATA_WIDTH-1:0] drp_data;
    logic eos;
    // Watchdog handshake
    logic timer_start;
    logic timer_stop;
    logic expired;
    // Sequencer to store
    measurement_t sample;
    logic new_sample;
    logic fault;

    // Write port and analog pins are tied off, status beyond EOS is not used
    xadc_bfm u_xadc (
        .dclk_in(dclk_in), .reset_in(reset_in),
        .drp_req(drp_req), .di_in('0), .dwe_in(1'b0),
        .drdy_out(drdy), .do_out(drp_data),
        .vp_in(1'b0), .vn_in(1'b0),
        .vauxp4(1'b0), .vauxn4(1'b0), .vauxp12(1'b0), .vauxn12(1'b0),
        .channel_out(), .eoc_out(), .alarm_out(), .eos_out(eos), .busy_out()
    );

    drp_read_sequencer u_sequencer (
        .dclk_in(dclk_in), .reset_in(reset_in),
        .eos(eos), .drdy(drdy), .drp_data(drp_data), .expired(expired),
        .drp_req(drp_req), .timer_start(timer_start), .timer_stop(timer_stop),
        .sample(sample), .new_sample(new_sample), .fault(fault), .busy(busy)
    );

    drp_watchdog_timer u_timer (
        .dclk_in(dclk_in), .reset_in(reset_in),
        .timer_start(timer_start), .timer_stop(timer_stop), .expired(expired)
    );

    measurement_store u_store (
        .dclk_in(dclk_in), .reset_in(reset_in),
        .sample(sample), .new_sample(new_sample), .fault(fault), .clear_peak(clear_peak),
        .measurement(measurement), .sample_valid(sample_valid),
        .peak_current(peak_current), .fault_count(fault_count)
    );

endmodule

/* sources.f */
source/xadc_drp_package.sv
source/xadc_bfm.sv
source/drp_read_sequencer.sv
source/drp_watchdog_timer.sv
source/measurement_store.sv
source/xadc_monitor_top.sv
testbench/xadc_monitor_asserts.sv
testbench/xadc_monitor_checker.sv
testbench/xadc_monitor_tb.sv

/* testbench/xadc_monitor_asserts.sv */
`timescale 1ns/1ps

module xadc_monitor_asserts (
    input logic dclk_in,
    input logic reset_in,
    input logic den,
    input logic drdy,
    input logic expired,
    input logic new_sample
);
    // Read issued, not yet answered or abandoned
    logic outstanding;
    // Read by the testbench top for its final verdict
    int assert_failures = 0;

    always_ff @(posedge dclk_in) begin
        if (reset_in) begin
            outstanding <= 1'b0;
        end else if (den) begin
            outstanding <= 1'b1;
        end else if (drdy || expired) begin
            outstanding <= 1'b0;
        end
    end

    // One read at a time on the DRP
    assert property (@(posedge dclk_in) disable iff (reset_in) den |-> !outstanding)
        else begin
            $error("den raised while a DRP read is outstanding");
            assert_failures++;
        end

    // Record strobe lasts one cycle
    assert property (@(posedge dclk_in) disable iff (reset_in) new_sample |=> !new_sample)
        else begin
            $error("new_sample held for more than one cycle");
            assert_failures++;
        end

    // An answered read never times out
    assert property (@(posedge dclk_in) disable iff (reset_in) drdy |-> !expired)
        else begin
            $error("expired fired together with drdy");
            assert_failures++;
        end

    assert property (@(posedge dclk_in) disable iff (reset_in) drdy |=> !expired)
        else begin
            $error("expired fired right after drdy");
            assert_failures++;
        end

endmodule

/* testbench/xadc_monitor_checker.sv */
`timescale 1ns/1ps

module xadc_monitor_checker (
    input  logic dclk_in,
    input  logic reset_in,
    input  logic clear_peak,
    input  xadc_drp_package::measurement_t measurement,
    input  logic sample_valid,
    input  logic [xadc_drp_package::XADC_DRP_DATA_WIDTH-1:0] peak_current,
    input  logic [xadc_drp_package::FAULT_COUNT_WIDTH-1:0] fault_count,
    input  logic busy,
    output logic checks_done,
    output int error_count,
    output logic wait_timeout
);
    import xadc_drp_package::*;

    localparam int WAIT_LIMIT = 200;
    localparam int SAMPLE_COUNT = 40;

    // Clear strobes the store has seen so far
    int clear_count = 0;

    always @(posedge dclk_in) begin
        if (clear_peak) begin
            clear_count <= clear_count + 1;
        end
    end

    // Ramp values of the simulated converter for sample n
    function automatic measurement_t expected_sample(input int n);
        measurement_t m;
        m.current = CURRENT_INIT + CURRENT_STEP * 16'(n);
        m.voltage = VOLTAGE_INIT + VOLTAGE_STEP * 16'(n);
        return m;
    endfunction

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual, inout int errors);
        if (actual !== expected) begin
            $display("FAIL %0d ns %s expected %0d actual %0d", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors, inout int failed);
        if (errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors);
            failed++;
        end
    endtask

    initial begin : compare
        int n;
        int waited;
        int clears_used;
        int failed;
        int reset_errors;
        int field_errors;
        int busy_errors;
        int peak_errors;
        int fault_errors;
        logic saw_busy;
        logic [XADC_DRP_DATA_WIDTH-1:0] ref_peak;
        measurement_t exp;
        checks_done = 1'b0;
        error_count = 0;
        wait_timeout = 1'b0;
        clears_used = 0;
        failed = 0;
        reset_errors = 0;
        field_errors = 0;
        busy_errors = 0;
        peak_errors = 0;
        fault_errors = 0;
        ref_peak = '0;
        // Leave reset
        waited = 0;
        do begin
            @(posedge dclk_in);
            waited++;
        end while (reset_in && waited < WAIT_LIMIT);
        // Idle monitor until the first read sequence starts
        check_value("busy", 16'd0, 16'(busy), reset_errors);
        waited = 0;
        while (!busy && waited < WAIT_LIMIT) begin
            check_value("sample_valid", 16'd0, 16'(sample_valid), reset_errors);
            check_value("measurement.current", 16'd0, measurement.current, reset_errors);
            check_value("measurement.voltage", 16'd0, measurement.voltage, reset_errors);
            check_value("peak_current", 16'd0, peak_current, reset_errors);
            check_value("fault_count", 16'd0, 16'(fault_count), reset_errors);
            @(posedge dclk_in);
            waited++;
        end
        if (!busy) begin
            $display("busy never rose after reset within %0d cycles", WAIT_LIMIT);
            reset_errors++;
            wait_timeout = 1'b1;
        end
        report_test("reset state", reset_errors, failed);
        for (n = 0; n < SAMPLE_COUNT && !wait_timeout; n++) begin
            saw_busy = 1'b0;
            waited = 0;
            do begin
                if (busy) begin
                    saw_busy = 1'b1;
                end
                // Peak holds and no fault shows up between samples
                check_value("peak_current", ref_peak, peak_current, peak_errors);
                check_value("fault_count", 16'd0, 16'(fault_count), fault_errors);
                @(posedge dclk_in);
                waited++;
            end while (!sample_valid && waited < WAIT_LIMIT);
            if (!sample_valid) begin
                $display("no sample arrived within %0d cycles for sample %0d", WAIT_LIMIT, n);
                busy_errors++;
                wait_timeout = 1'b1;
            end else begin
                exp = expected_sample(n);
                check_value("measurement.current", exp.current, measurement.current,
                            field_errors);
                check_value("measurement.voltage", exp.voltage, measurement.voltage,
                            field_errors);
                if (!saw_busy) begin
                    $display("busy did not rise before sample %0d", n);
                    busy_errors++;
                end
                check_value("busy", 16'd0, 16'(busy), busy_errors);
                // A clear since the last sample restarts the peak here
                if (clear_count != clears_used || exp.current > ref_peak) begin
                    ref_peak = exp.current;
                end
                clears_used = clear_count;
                check_value("peak_current", ref_peak, peak_current, peak_errors);
                check_value("fault_count", 16'd0, 16'(fault_count), fault_errors);
            end
        end
        report_test("measurement fields", field_errors, failed);
        report_test("busy framing", busy_errors, failed);
        report_test("peak tracking", peak_errors, failed);
        report_test("fault count", fault_errors, failed);
        $display("tests run 5, passed %0d, failed %0d, samples %0d, clears %0d",
                 5 - failed, failed, n, clear_count);
        error_count = reset_errors + field_errors + busy_errors + peak_errors + fault_errors;
        checks_done = 1'b1;
    end

endmodule

/* testbench/xadc_monitor_tb.sv */
`timescale 1ns/1ps

module xadc_monitor_tb;
    import xadc_drp_package::*;

    // Bound on the whole run in clock cycles
    localparam int FINISH_LIMIT = 20000;

    logic dclk_in = 1'b0;
    logic reset_in = 1'b1;
    logic clear_peak = 1'b0;
    measurement_t measurement;
    logic sample_valid;
    logic [XADC_DRP_DATA_WIDTH-1:0] peak_current;
    logic [FAULT_COUNT_WIDTH-1:0] fault_count;
    logic busy;
    // Checker status
    logic checks_done;
    int error_count;
    logic wait_timeout;
    integer seed = 24413;

    // 8 ns clock
    always #4 dclk_in = ~dclk_in;

    // Reset held for 10 cycles
    initial begin : reset_sequence
        repeat (10) @(posedge dclk_in);
        reset_in <= 1'b0;
    end

    // Random clear of the peak right after some samples
    always @(posedge dclk_in) begin
        if (!reset_in && sample_valid && ($unsigned($random(seed)) % 3 == 0)) begin
            clear_peak <= 1'b1;
        end else begin
            clear_peak <= 1'b0;
        end
    end

    xadc_monitor_top dut (
        .dclk_in(dclk_in), .reset_in(reset_in), .clear_peak(clear_peak),
        .measurement(measurement), .sample_valid(sample_valid),
        .peak_current(peak_current), .fault_count(fault_count), .busy(busy)
    );

    xadc_monitor_checker u_checker (
        .dclk_in(dclk_in), .reset_in(reset_in), .clear_peak(clear_peak),
        .measurement(measurement), .sample_valid(sample_valid),
        .peak_current(peak_current), .fault_count(fault_count), .busy(busy),
        .checks_done(checks_done), .error_count(error_count), .wait_timeout(wait_timeout)
    );

    // DRP handshake and strobe properties on the sequencer
    bind drp_read_sequencer xadc_monitor_asserts u_asserts (
        .dclk_in(dclk_in), .reset_in(reset_in), .den(drp_req.den),
        .drdy(drdy), .expired(expired), .new_sample(new_sample)
    );

    initial begin : final_report
        int waited;
        waited = 0;
        do begin
            @(posedge dclk_in);
            waited++;
        end while (!checks_done && waited < FINISH_LIMIT);
        if (checks_done && !wait_timeout && error_count == 0 &&
            dut.u_sequencer.u_asserts.assert_failures == 0) begin
            $display("Verification passed");
        end else begin
            if (!checks_done) begin
                $display("checker did not finish within %0d cycles", FINISH_LIMIT);
            end
            if (dut.u_sequencer.u_asserts.assert_failures != 0) begin
                $display("%0d assertion failures", dut.u_sequencer.u_asserts.assert_failures);
            end
            $display("Verification failed");
        end
        $finish;
    end

endmodule
